// File: include/ntm_config.svh
`ifndef NTM_CONFIG_SVH
`define NTM_CONFIG_SVH

// Word format
// Signed Q8.8 for operands and results
`define NTM_DATA_W 16
`define NTM_FRAC_W 8

// Q16.16 sum of full products with integer headroom
`define NTM_ACC_W 40

// Vector lengths
// x has X elements and r has W elements
`define NTM_SIZE_X 4
`define NTM_SIZE_W 4
// Controller length sets rows of W K U and length of h b
`define NTM_SIZE_L 4

// Load and read address
// Upper half is the row and lower half the column
`define NTM_ADDR_W 4

`endif

// File: logic/ntm_pkg.sv
`include "ntm_config.svh"

package ntm_pkg;

  //////////////////////////////
  // Operand selector
  //////////////////////////////

  // Load side uses every code
  // Read side uses W K U for the product pairs and B for the bias
  typedef enum logic [2:0] {
    OP_W = 3'd0,
    OP_X = 3'd1,
    OP_K = 3'd2,
    OP_R = 3'd3,
    OP_U = 3'd4,
    OP_H = 3'd5,
    OP_B = 3'd6
  } ntm_operand_e;

  //////////////////////////////
  // Fixed point word
  //////////////////////////////

  // One Q8.8 word
  // Arithmetic goes through value
  // Range checks look at the fields
  typedef union packed {
    logic signed [`NTM_DATA_W-1:0] value;
    struct packed {
      logic                               sign;
      logic [`NTM_DATA_W-`NTM_FRAC_W-2:0] int_part;
      logic [`NTM_FRAC_W-1:0]             frac;
    } parts;
  } ntm_fixed_u;

endpackage

// File: logic/ntm_ifs.sv
`timescale 1ns/1ps
`include "ntm_config.svh"

//////////////////////////////
// Operand read bus
//////////////////////////////

interface ntm_operand_if;
  import ntm_pkg::*;

  // Read request from the controller
  ntm_operand_e                sel;
  logic [`NTM_ADDR_W/2-1:0]    row;
  logic [`NTM_ADDR_W/2-1:0]    col;
  logic                        rd;

  // Registered read data
  // Matrix element on a and vector or bias element on b
  logic [`NTM_DATA_W-1:0]      data_a;
  logic [`NTM_DATA_W-1:0]      data_b;

  modport controller (
    output sel, row, col, rd
  );

  modport store (
    input  sel, row, col, rd,
    output data_a, data_b
  );

  // Accumulator only sees the data words
  modport data (
    input data_a, data_b
  );
endinterface

//////////////////////////////
// MAC control bus
//////////////////////////////

interface ntm_mac_if;
  import ntm_pkg::*;

  // Strobes from the controller
  logic       clear;
  logic       accumulate;
  logic       add_bias;
  logic       finish;

  // Saturated Q8.8 result
  ntm_fixed_u sum_q;
  logic       sum_valid;

  modport controller (
    output clear, accumulate, add_bias, finish,
    input  sum_valid
  );

  modport accumulator (
    input  clear, accumulate, add_bias, finish,
    output sum_q, sum_valid
  );
endinterface

// File: logic/ntm_operand_store.sv
`timescale 1ns/1ps
`include "ntm_config.svh"

module ntm_operand_store (
  input  logic                   CLK,
  input  logic                   RST,
  input  logic                   LOAD_ENABLE,
  input  ntm_pkg::ntm_operand_e  LOAD_SEL,
  input  logic [`NTM_ADDR_W-1:0] LOAD_ADDR,
  input  logic [`NTM_DATA_W-1:0] LOAD_DATA,
  ntm_operand_if.store           op
);
  import ntm_pkg::*;

  localparam int IDX_W = `NTM_ADDR_W / 2;

  // Load address fields
  logic [IDX_W-1:0] ld_row;
  logic [IDX_W-1:0] ld_col;

  // Matrices are L rows
  logic [`NTM_DATA_W-1:0] w_mem [`NTM_SIZE_L][`NTM_SIZE_X];
  logic [`NTM_DATA_W-1:0] k_mem [`NTM_SIZE_L][`NTM_SIZE_W];
  logic [`NTM_DATA_W-1:0] u_mem [`NTM_SIZE_L][`NTM_SIZE_L];
  // Vectors
  logic [`NTM_DATA_W-1:0] x_vec [`NTM_SIZE_X];
  logic [`NTM_DATA_W-1:0] r_vec [`NTM_SIZE_W];
  logic [`NTM_DATA_W-1:0] h_vec [`NTM_SIZE_L];
  logic [`NTM_DATA_W-1:0] b_vec [`NTM_SIZE_L];

  // Vector elements are addressed by the column field
  assign ld_row = LOAD_ADDR[`NTM_ADDR_W-1:IDX_W];
  assign ld_col = LOAD_ADDR[IDX_W-1:0];

  //////////////////////////////
  // Load decoder
  //////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      for (int i = 0; i < `NTM_SIZE_L; i++) begin
        for (int j = 0; j < `NTM_SIZE_X; j++) w_mem[i][j] <= '0;
        for (int j = 0; j < `NTM_SIZE_W; j++) k_mem[i][j] <= '0;
        for (int j = 0; j < `NTM_SIZE_L; j++) u_mem[i][j] <= '0;
        h_vec[i] <= '0;
        b_vec[i] <= '0;
      end
      for (int j = 0; j < `NTM_SIZE_X; j++) x_vec[j] <= '0;
      for (int j = 0; j < `NTM_SIZE_W; j++) r_vec[j] <= '0;
    end else if (LOAD_ENABLE) begin
      // One element per strobe
      case (LOAD_SEL)
        OP_W:    w_mem[ld_row][ld_col] <= LOAD_DATA;
        OP_X:    x_vec[ld_col] <= LOAD_DATA;
        OP_K:    k_mem[ld_row][ld_col] <= LOAD_DATA;
        OP_R:    r_vec[ld_col] <= LOAD_DATA;
        OP_U:    u_mem[ld_row][ld_col] <= LOAD_DATA;
        OP_H:    h_vec[ld_col] <= LOAD_DATA;
        OP_B:    b_vec[ld_col] <= LOAD_DATA;
        default: ;
      endcase
    end
  end

  //////////////////////////////
  // Read port
  //////////////////////////////

  // Pair comes out one cycle after the strobe
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      op.data_a <= '0;
      op.data_b <= '0;
    end else if (op.rd) begin
      case (op.sel)
        OP_W: begin
          op.data_a <= w_mem[op.row][op.col];
          op.data_b <= x_vec[op.col];
        end
        OP_K: begin
          op.data_a <= k_mem[op.row][op.col];
          op.data_b <= r_vec[op.col];
        end
        OP_U: begin
          op.data_a <= u_mem[op.row][op.col];
          op.data_b <= h_vec[op.col];
        end
        // Bias of the current row on b
        OP_B: begin
          op.data_a <= '0;
          op.data_b <= b_vec[op.row];
        end
        default: begin
          op.data_a <= '0;
          op.data_b <= '0;
        end
      endcase
    end
  end

endmodule

// File: logic/ntm_dot_accumulator.sv
`timescale 1ns/1ps
`include "ntm_config.svh"

module ntm_dot_accumulator (
  input logic            CLK,
  input logic            RST,
  ntm_mac_if.accumulator mac,
  ntm_operand_if.data    op
);

  localparam int PROD_W = 2 * `NTM_DATA_W;
  // Q8.8 output range held in accumulator width
  localparam logic signed [`NTM_ACC_W-1:0] SAT_MAX = 2 ** (`NTM_DATA_W - 1) - 1;
  localparam logic signed [`NTM_ACC_W-1:0] SAT_MIN = -(2 ** (`NTM_DATA_W - 1));

  logic signed [PROD_W-1:0]     product;
  logic signed [`NTM_ACC_W-1:0] product_ext;
  logic signed [`NTM_ACC_W-1:0] bias_ext;
  logic signed [`NTM_ACC_W-1:0] acc_sum;
  logic signed [`NTM_ACC_W-1:0] scaled;

  // Full Q16.16 product
  assign product     = $signed(op.data_a) * $signed(op.data_b);
  assign product_ext = {{(`NTM_ACC_W-PROD_W){product[PROD_W-1]}}, product};

  // Bias moved to Q16.16
  assign bias_ext = {{(`NTM_ACC_W-`NTM_DATA_W){op.data_b[`NTM_DATA_W-1]}}, op.data_b}
                    << `NTM_FRAC_W;

  // Back to Q8.8 with sign kept
  assign scaled = acc_sum >>> `NTM_FRAC_W;

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      acc_sum       <= '0;
      mac.sum_q     <= '0;
      mac.sum_valid <= 1'b0;
    end else begin
      mac.sum_valid <= mac.finish;
      // Clear wins over any strobe
      if (mac.clear)
        acc_sum <= '0;
      else if (mac.accumulate)
        acc_sum <= acc_sum + product_ext;
      else if (mac.add_bias)
        acc_sum <= acc_sum + bias_ext;
      // Saturate into one word
      if (mac.finish) begin
        if (scaled > SAT_MAX)
          mac.sum_q.value <= SAT_MAX[`NTM_DATA_W-1:0];
        else if (scaled < SAT_MIN)
          mac.sum_q.value <= SAT_MIN[`NTM_DATA_W-1:0];
        else
          mac.sum_q.value <= scaled[`NTM_DATA_W-1:0];
      end
    end
  end

endmodule

// File: logic/ntm_vector_logistic.sv
`timescale 1ns/1ps
`include "ntm_config.svh"

module ntm_vector_logistic (
  input  logic                     CLK,
  input  logic                     RST,
  input  logic                     start,
  input  ntm_pkg::ntm_fixed_u      z_in,
  input  logic [`NTM_ADDR_W/2-1:0] index_in,
  output logic                     result_enable,
  output logic [`NTM_DATA_W-1:0]   result,
  output logic [`NTM_ADDR_W/2-1:0] result_index
);
  import ntm_pkg::*;

  // 1.0 in Q8.8
  localparam logic [`NTM_DATA_W-1:0] ONE = 1 << `NTM_FRAC_W;
  // Most negative word has no positive twin
  localparam logic signed [`NTM_DATA_W-1:0] MOST_NEG = -(2 ** (`NTM_DATA_W - 1));
  localparam logic signed [`NTM_DATA_W-1:0] MOST_POS = 2 ** (`NTM_DATA_W - 1) - 1;
  // Region edges 5.0 and 2.375 as integer and fraction fields
  localparam logic [`NTM_DATA_W-`NTM_FRAC_W-2:0] SAT_INT = 5;
  localparam logic [`NTM_DATA_W-`NTM_FRAC_W-2:0] MID_INT = 2;
  localparam logic [`NTM_FRAC_W-1:0]             MID_FRAC = 96;

  ntm_fixed_u                mag;
  logic [`NTM_DATA_W-1:0]    y;

  always_comb begin
    // Magnitude of z
    if (!z_in.parts.sign)
      mag.value = z_in.value;
    else if (z_in.value == MOST_NEG)
      mag.value = MOST_POS;
    else
      mag.value = -z_in.value;

    // PLAN regions on the positive side
    if (mag.parts.int_part >= SAT_INT)
      y = ONE;
    else if (mag.parts.int_part > MID_INT ||
             (mag.parts.int_part == MID_INT && mag.parts.frac >= MID_FRAC))
      y = (mag.value >> 5) + 16'd216;
    else if (mag.parts.int_part != '0)
      y = (mag.value >> 3) + 16'd160;
    else
      y = (mag.value >> 2) + 16'd128;
  end

  //////////////////////////////
  // Output register
  //////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      result_enable <= 1'b0;
      result        <= '0;
      result_index  <= '0;
    end else begin
      result_enable <= start;
      if (start) begin
        // Mirror around one half for negative z
        result       <= z_in.parts.sign ? ONE - y : y;
        result_index <= index_in;
      end
    end
  end

endmodule

// File: logic/ntm_forget_controller.sv
`timescale 1ns/1ps
`include "ntm_config.svh"

module ntm_forget_controller (
  input  logic                     CLK,
  input  logic                     RST,
  input  logic                     START,
  output logic                     READY,
  ntm_operand_if.controller        op,
  ntm_mac_if.controller            mac,
  output logic                     logistic_start,
  output logic [`NTM_ADDR_W/2-1:0] logistic_index
);
  import ntm_pkg::*;

  localparam int IDX_W = `NTM_ADDR_W / 2;
  // Last column of each dot product
  localparam logic [IDX_W-1:0] LAST_X = IDX_W'(`NTM_SIZE_X - 1);
  localparam logic [IDX_W-1:0] LAST_W = IDX_W'(`NTM_SIZE_W - 1);
  localparam logic [IDX_W-1:0] LAST_L = IDX_W'(`NTM_SIZE_L - 1);

  typedef enum logic [2:0] {
    S_IDLE,
    S_WX,
    S_KR,
    S_UH,
    S_BIAS,
    S_FINISH,
    S_WAIT_SUM,
    S_DONE
  } state_e;

  state_e           state;
  state_e           issue_next;
  ntm_operand_e     issue_sel;
  logic [IDX_W-1:0] issue_last;
  logic [IDX_W-1:0] row_cnt;
  logic [IDX_W-1:0] col_cnt;
  // Finish waits one extra cycle behind the bias add
  logic             fin_p;

  //////////////////////////////
  // Product phase decode
  //////////////////////////////

  always_comb begin
    case (state)
      S_KR: begin
        issue_sel  = OP_K;
        issue_last = LAST_W;
        issue_next = S_UH;
      end
      S_UH: begin
        issue_sel  = OP_U;
        issue_last = LAST_L;
        issue_next = S_BIAS;
      end
      default: begin
        issue_sel  = OP_W;
        issue_last = LAST_X;
        issue_next = S_KR;
      end
    endcase
  end

  //////////////////////////////
  // FSM and strobe pipeline
  //////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state          <= S_IDLE;
      READY          <= 1'b1;
      row_cnt        <= '0;
      col_cnt        <= '0;
      op.rd          <= 1'b0;
      op.sel         <= OP_W;
      op.row         <= '0;
      op.col         <= '0;
      mac.clear      <= 1'b0;
      mac.accumulate <= 1'b0;
      mac.add_bias   <= 1'b0;
      mac.finish     <= 1'b0;
      fin_p          <= 1'b0;
      logistic_start <= 1'b0;
      logistic_index <= '0;
    end else begin
      // Single cycle strobes
      op.rd          <= 1'b0;
      mac.clear      <= 1'b0;
      fin_p          <= 1'b0;
      logistic_start <= 1'b0;

      // Data of the read in flight lands next cycle
      mac.accumulate <= op.rd && (op.sel != OP_B);
      mac.add_bias   <= op.rd && (op.sel == OP_B);
      mac.finish     <= fin_p;

      case (state)
        S_IDLE: begin
          if (START) begin
            READY     <= 1'b0;
            row_cnt   <= '0;
            col_cnt   <= '0;
            mac.clear <= 1'b1;
            state     <= S_WX;
          end
        end

        // One read per cycle across W.x then K.r then U.h
        S_WX, S_KR, S_UH: begin
          op.rd  <= 1'b1;
          op.sel <= issue_sel;
          op.row <= row_cnt;
          op.col <= col_cnt;
          if (col_cnt == issue_last) begin
            col_cnt <= '0;
            state   <= issue_next;
          end else begin
            col_cnt <= col_cnt + 1'b1;
          end
        end

        S_BIAS: begin
          op.rd  <= 1'b1;
          op.sel <= OP_B;
          op.row <= row_cnt;
          state  <= S_FINISH;
        end

        S_FINISH: begin
          fin_p <= 1'b1;
          state <= S_WAIT_SUM;
        end

        // Row sum ready so hand it to the sigmoid
        S_WAIT_SUM: begin
          if (mac.sum_valid) begin
            logistic_start <= 1'b1;
            logistic_index <= row_cnt;
            if (row_cnt == LAST_L) begin
              state <= S_DONE;
            end else begin
              row_cnt   <= row_cnt + 1'b1;
              mac.clear <= 1'b1;
              state     <= S_WX;
            end
          end
        end

        // Last sigmoid in flight
        // READY follows its result by one cycle
        S_DONE: begin
          if (!logistic_start) begin
            READY <= 1'b1;
            state <= S_IDLE;
          end
        end

        default: state <= S_IDLE;
      endcase
    end
  end

endmodule

// File: logic/ntm_forget_gate_vector.sv
`timescale 1ns/1ps
`include "ntm_config.svh"

module ntm_forget_gate_vector (
  input  logic                     CLK,
  input  logic                     RST,

  // Run control
  input  logic                     START,
  output logic                     READY,

  // Operand load port
  input  logic                     LOAD_ENABLE,
  input  ntm_pkg::ntm_operand_e    LOAD_SEL,
  input  logic [`NTM_ADDR_W-1:0]   LOAD_ADDR,
  input  logic [`NTM_DATA_W-1:0]   LOAD_DATA,

  // Result stream in row order
  output logic                     F_OUT_ENABLE,
  output logic [`NTM_DATA_W-1:0]   F_OUT,
  output logic [`NTM_ADDR_W/2-1:0] F_OUT_INDEX
);

  //////////////////////////////
  // Internal buses
  //////////////////////////////

  ntm_operand_if op_bus ();
  ntm_mac_if     mac_bus ();

  logic                     logistic_start;
  logic [`NTM_ADDR_W/2-1:0] logistic_index;

  //////////////////////////////
  // Blocks
  //////////////////////////////

  ntm_forget_controller u_controller (
    .CLK            (CLK),
    .RST            (RST),
    .START          (START),
    .READY          (READY),
    .op             (op_bus),
    .mac            (mac_bus),
    .logistic_start (logistic_start),
    .logistic_index (logistic_index)
  );

  // Host writes land here directly
  ntm_operand_store u_store (
    .CLK         (CLK),
    .RST         (RST),
    .LOAD_ENABLE (LOAD_ENABLE),
    .LOAD_SEL    (LOAD_SEL),
    .LOAD_ADDR   (LOAD_ADDR),
    .LOAD_DATA   (LOAD_DATA),
    .op          (op_bus)
  );

  ntm_dot_accumulator u_accumulator (
    .CLK (CLK),
    .RST (RST),
    .mac (mac_bus),
    .op  (op_bus)
  );

  // Sigmoid reads the held row sum
  ntm_vector_logistic u_logistic (
    .CLK           (CLK),
    .RST           (RST),
    .start         (logistic_start),
    .z_in          (mac_bus.sum_q),
    .index_in      (logistic_index),
    .result_enable (F_OUT_ENABLE),
    .result        (F_OUT),
    .result_index  (F_OUT_INDEX)
  );

endmodule

// File: test/ntm_forget_gate_checker.sv
`timescale 1ns/1ps
`include "ntm_config.svh"

module ntm_forget_gate_checker (
  input  logic                     CLK,
  input  logic                     RST,
  input  logic                     START,
  input  logic                     READY,
  input  logic                     LOAD_ENABLE,
  input  ntm_pkg::ntm_operand_e    LOAD_SEL,
  input  logic [`NTM_ADDR_W-1:0]   LOAD_ADDR,
  input  logic [`NTM_DATA_W-1:0]   LOAD_DATA,
  input  logic                     F_OUT_ENABLE,
  input  logic [`NTM_DATA_W-1:0]   F_OUT,
  input  logic [`NTM_ADDR_W/2-1:0] F_OUT_INDEX,
  output int                       result_count,
  output int                       error_count
);
  import ntm_pkg::*;

  localparam int IDX_W = `NTM_ADDR_W / 2;
  localparam int L     = `NTM_SIZE_L;
  localparam int X     = `NTM_SIZE_X;
  localparam int WS    = `NTM_SIZE_W;

  // Shadow of the operand store
  logic [`NTM_DATA_W-1:0] w_sh [L][X];
  logic [`NTM_DATA_W-1:0] k_sh [L][WS];
  logic [`NTM_DATA_W-1:0] u_sh [L][L];
  logic [`NTM_DATA_W-1:0] x_sh [X];
  logic [`NTM_DATA_W-1:0] r_sh [WS];
  logic [`NTM_DATA_W-1:0] h_sh [L];
  logic [`NTM_DATA_W-1:0] b_sh [L];
  // Expected gates frozen when a run starts
  logic [`NTM_DATA_W-1:0] exp_vals [L];

  logic [IDX_W-1:0] ld_row;
  logic [IDX_W-1:0] ld_col;
  bit               run_active;
  bit               prev_ready;
  bit               after_reset;
  bit               start_taken;
  bit               last_pulse;
  int               pulse_count;

  assign ld_row = LOAD_ADDR[`NTM_ADDR_W-1:IDX_W];
  assign ld_col = LOAD_ADDR[IDX_W-1:0];

  //////////////////////////////
  // Reference model
  //////////////////////////////

  // f(l) from the shadow operands
  function automatic logic [`NTM_DATA_W-1:0] model_gate(int l);
    longint acc;
    longint z;
    longint a;
    longint y;
    acc = 0;
    for (int c = 0; c < X; c++)
      acc += longint'($signed(w_sh[l][c])) * longint'($signed(x_sh[c]));
    for (int c = 0; c < WS; c++)
      acc += longint'($signed(k_sh[l][c])) * longint'($signed(r_sh[c]));
    for (int c = 0; c < L; c++)
      acc += longint'($signed(u_sh[l][c])) * longint'($signed(h_sh[c]));
    // Bias joins at Q16.16
    acc += longint'($signed(b_sh[l])) * 256;
    z = acc >>> 8;
    if (z > 32767)
      z = 32767;
    else if (z < -32768)
      z = -32768;
    // Magnitude clipped for the most negative word
    a = (z < 0) ? -z : z;
    if (a > 32767)
      a = 32767;
    // PLAN regions
    if (a >= 1280)
      y = 256;
    else if (a >= 608)
      y = (a >> 5) + 216;
    else if (a >= 256)
      y = (a >> 3) + 160;
    else
      y = (a >> 2) + 128;
    if (z < 0)
      y = 256 - y;
    return `NTM_DATA_W'(y);
  endfunction

  //////////////////////////////
  // Monitor
  //////////////////////////////

  always @(posedge CLK or posedge RST) begin
    if (RST) begin
      for (int i = 0; i < L; i++) begin
        for (int j = 0; j < X; j++) w_sh[i][j] = '0;
        for (int j = 0; j < WS; j++) k_sh[i][j] = '0;
        for (int j = 0; j < L; j++) u_sh[i][j] = '0;
        h_sh[i] = '0;
        b_sh[i] = '0;
      end
      for (int j = 0; j < X; j++) x_sh[j] = '0;
      for (int j = 0; j < WS; j++) r_sh[j] = '0;
      run_active   = 1'b0;
      prev_ready   = 1'b1;
      after_reset  = 1'b1;
      start_taken  = 1'b0;
      last_pulse   = 1'b0;
      pulse_count  = 0;
      result_count = 0;
      error_count  = 0;
    end else begin
      // First cycle out of reset
      if (after_reset) begin
        after_reset = 1'b0;
        if (READY !== 1'b1) begin
          $display("ERROR READY expected %h got %h", 1'b1, READY);
          error_count++;
        end
        if (F_OUT_ENABLE !== 1'b0) begin
          $display("ERROR F_OUT_ENABLE expected %h got %h", 1'b0, F_OUT_ENABLE);
          error_count++;
        end
      end

      // READY drops the cycle after an accepted START
      if (start_taken && READY !== 1'b0) begin
        $display("ERROR READY expected %h got %h", 1'b0, READY);
        error_count++;
      end

      // READY rises the cycle after the last result
      if (last_pulse && READY !== 1'b1) begin
        $display("ERROR READY expected %h got %h", 1'b1, READY);
        error_count++;
      end
      last_pulse = 1'b0;

      // Result pulses in row order
      if (F_OUT_ENABLE) begin
        if (!run_active) begin
          $display("Result pulse seen with no run in progress");
          error_count++;
        end else if (pulse_count >= L) begin
          $display("More results than rows in one run");
          error_count++;
        end else begin
          if (F_OUT_INDEX !== IDX_W'(pulse_count)) begin
            $display("ERROR F_OUT_INDEX expected %h got %h",
                     IDX_W'(pulse_count), F_OUT_INDEX);
            error_count++;
          end
          if (F_OUT !== exp_vals[pulse_count]) begin
            $display("ERROR F_OUT row %0d expected %h got %h",
                     pulse_count, exp_vals[pulse_count], F_OUT);
            error_count++;
          end
          result_count++;
          pulse_count++;
          if (pulse_count == L)
            last_pulse = 1'b1;
        end
      end

      // READY back up closes the run
      if (READY && !prev_ready) begin
        if (!run_active) begin
          $display("READY rose with no run in progress");
          error_count++;
        end else if (pulse_count != L) begin
          $display("Run gave %0d results instead of %0d", pulse_count, L);
          error_count++;
        end
        run_active = 1'b0;
      end

      // Writes land before any read of this run
      if (LOAD_ENABLE) begin
        case (LOAD_SEL)
          OP_W: w_sh[ld_row][ld_col] = LOAD_DATA;
          OP_X: x_sh[ld_col] = LOAD_DATA;
          OP_K: k_sh[ld_row][ld_col] = LOAD_DATA;
          OP_R: r_sh[ld_col] = LOAD_DATA;
          OP_U: u_sh[ld_row][ld_col] = LOAD_DATA;
          OP_H: h_sh[ld_col] = LOAD_DATA;
          OP_B: b_sh[ld_col] = LOAD_DATA;
          default: ;
        endcase
      end

      // Accepted START
      if (START && READY) begin
        for (int i = 0; i < L; i++)
          exp_vals[i] = model_gate(i);
        run_active  = 1'b1;
        pulse_count = 0;
      end
      start_taken = START && READY;
      prev_ready  = READY;
    end
  end

endmodule

// File: test/ntm_forget_gate_tb.sv
`timescale 1ns/1ps
`include "ntm_config.svh"

module ntm_forget_gate_tb;
  import ntm_pkg::*;

  localparam int ADDR_W = `NTM_ADDR_W;
  localparam int IDX_W  = `NTM_ADDR_W / 2;
  localparam int L      = `NTM_SIZE_L;
  localparam int X      = `NTM_SIZE_X;
  localparam int WS     = `NTM_SIZE_W;

  // Operand modes
  localparam int MODE_ZERO     = 0;
  localparam int MODE_MODERATE = 1;
  localparam int MODE_LARGE    = 2;

  // Run length limit
  localparam int FULL_LOAD      = L * X + X + L * WS + WS + L * L + L + L;
  localparam int RUN_CYCLES     = L * (X + WS + L + 3) + 10;
  localparam int TEST_LOADS     = 6 * FULL_LOAD + 8 * L;
  localparam int TEST_RUNS      = 15;
  localparam int TIMEOUT_CYCLES = 2 * (TEST_LOADS + TEST_RUNS * RUN_CYCLES);

  logic                   CLK;
  logic                   RST;
  logic                   START;
  logic                   READY;
  logic                   LOAD_ENABLE;
  ntm_operand_e           LOAD_SEL;
  logic [ADDR_W-1:0]      LOAD_ADDR;
  logic [`NTM_DATA_W-1:0] LOAD_DATA;
  logic                   F_OUT_ENABLE;
  logic [`NTM_DATA_W-1:0] F_OUT;
  logic [IDX_W-1:0]       F_OUT_INDEX;

  int          result_count;
  int          error_count;
  int          cycle_count = 0;
  int          test_num;
  int          res_mark;
  int          err_mark;

  // Q8.8 words on and next to each sigmoid region edge
  int edge_vals [24] = '{0, 1, -1, 128, 255, 256, 257, -255, -256, -257,
                         607, 608, 609, -607, -608, -609, 1279, 1280, 1281,
                         -1279, -1280, -1281, 32767, -32768};

  ntm_forget_gate_vector dut0 (.*);

  ntm_forget_gate_checker chk0 (.*);

  always #20 CLK = ~CLK;

  // Watchdog
  always @(posedge CLK) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("Timeout after %0d cycles, the DUT never finished", cycle_count);
      $display("Checks failed");
      $finish;
    end
  end

  //////////////////////////////
  // Stimulus helpers
  //////////////////////////////

  function automatic logic [`NTM_DATA_W-1:0] rand_word(int mode);
    case (mode)
      MODE_ZERO:     return '0;
      // Within +-2.0
      MODE_MODERATE: return `NTM_DATA_W'(int'($urandom_range(1024, 0)) - 512);
      default:       return `NTM_DATA_W'($urandom);
    endcase
  endfunction

  task automatic load_word(input ntm_operand_e sel, input int row, input int col,
                           input logic [`NTM_DATA_W-1:0] data);
    @(posedge CLK);
    LOAD_ENABLE <= 1'b1;
    LOAD_SEL    <= sel;
    LOAD_ADDR   <= ADDR_W'((row << IDX_W) | col);
    LOAD_DATA   <= data;
  endtask

  task automatic load_idle();
    @(posedge CLK);
    LOAD_ENABLE <= 1'b0;
  endtask

  // Every operand in one pass
  task automatic load_all(input int mode);
    for (int i = 0; i < L; i++) begin
      for (int j = 0; j < X; j++) load_word(OP_W, i, j, rand_word(mode));
      for (int j = 0; j < WS; j++) load_word(OP_K, i, j, rand_word(mode));
      for (int j = 0; j < L; j++) load_word(OP_U, i, j, rand_word(mode));
      load_word(OP_H, 0, i, rand_word(mode));
      load_word(OP_B, 0, i, rand_word(mode));
    end
    for (int j = 0; j < X; j++) load_word(OP_X, 0, j, rand_word(mode));
    for (int j = 0; j < WS; j++) load_word(OP_R, 0, j, rand_word(mode));
    load_idle();
  endtask

  // One START then wait for READY
  // Stray STARTs land well inside the run
  task automatic run_vector(input bit stray_starts);
    int waited;
    @(posedge CLK);
    START <= 1'b1;
    @(posedge CLK);
    START <= 1'b0;
    waited = 0;
    do begin
      @(posedge CLK);
      waited++;
      if (stray_starts && (waited == 10 || waited == 30 || waited == 31))
        START <= 1'b1;
      else
        START <= 1'b0;
    end while (!READY);
  endtask

  task automatic report_test(input string name);
    @(negedge CLK);
    $display("test %0d %s: %0d results checked, %0d errors", test_num, name,
             result_count - res_mark, error_count - err_mark);
    test_num++;
    res_mark = result_count;
    err_mark = error_count;
  endtask

  //////////////////////////////
  // Test sequence
  //////////////////////////////

  initial begin
    CLK         = 1'b0;
    RST         = 1'b1;
    START       = 1'b0;
    LOAD_ENABLE = 1'b0;
    LOAD_SEL    = OP_W;
    LOAD_ADDR   = '0;
    LOAD_DATA   = '0;
    test_num    = 1;
    res_mark    = 0;
    err_mark    = 0;
    void'($urandom(32'h60b5));
    repeat (5) @(posedge CLK);
    RST <= 1'b0;

    // Idle after reset then all-zero operands
    repeat (8) @(posedge CLK);
    run_vector(1'b0);
    report_test("reset and zero operands");

    repeat (3) begin
      load_all(MODE_MODERATE);
      run_vector(1'b0);
    end
    report_test("random moderate operands");

    // Sums far past 5.0
    repeat (2) begin
      load_all(MODE_LARGE);
      run_vector(1'b0);
    end
    report_test("random large operands");

    repeat (2) begin
      for (int i = 0; i < L; i++)
        load_word(OP_H, 0, i, rand_word(MODE_MODERATE));
      load_idle();
      run_vector(1'b0);
    end
    report_test("reload h only");

    run_vector(1'b1);
    report_test("start during run");

    // Bias alone sets z
    load_all(MODE_ZERO);
    for (int g = 0; g < 24 / L; g++) begin
      for (int i = 0; i < L; i++)
        load_word(OP_B, 0, i, `NTM_DATA_W'(edge_vals[g * L + i]));
      load_idle();
      run_vector(1'b0);
    end
    report_test("region edges");

    @(negedge CLK);
    $display("%0d tests, %0d results checked, %0d errors", test_num - 1,
             result_count, error_count);
    if (error_count == 0)
      $display("All checks passed");
    else
      $display("Checks failed");
    $finish;
  end

endmodule

// File: all.f
+incdir+include
logic/ntm_pkg.sv
logic/ntm_ifs.sv
logic/ntm_operand_store.sv
logic/ntm_dot_accumulator.sv
logic/ntm_vector_logistic.sv
logic/ntm_forget_controller.sv
logic/ntm_forget_gate_vector.sv
test/ntm_forget_gate_checker.sv
test/ntm_forget_gate_tb.sv

// File: run.sh
#!/bin/sh
# Build the testbench with Verilator and run it once
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal --top-module ntm_forget_gate_tb \
  -f all.f -o ntm_sim || exit 1
sim_out=$(./obj_dir/ntm_sim)
printf '%s\n' "$sim_out"
# Pass only when the closing line says so
printf '%s\n' "$sim_out" | grep -qx "All checks passed" && exit 0 || exit 1
